//--- fp_predec.f
+incdir+verif
rtl/fp_isa_pkg.sv
rtl/fp_dec_pkg.sv
rtl/fp_ls_decode.sv
rtl/fp_op_decode.sv
rtl/fp_legal_check.sv
rtl/fp_predec.sv
verif/fp_predec_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fp_predec_tb
FILELIST  ?= fp_predec.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/fp_predec_ref.svh
// reference model of the FP predecoder record, included into the testbench module body
`ifndef FP_PREDEC_REF_SVH
`define FP_PREDEC_REF_SVH

function automatic fp_dec_t ref_decode(fp_instr_u w, logic c_dp_en, rm_t frm, fs_e fs,
                                       logic csr_acc, int flen);
    fp_dec_t     d;
    logic [31:0] b;
    logic        is_ld;
    logic        is_st;
    logic        dbl;
    logic        loads;
    logic        stores;
    logic [1:0]  fmt;
    logic [2:0]  f3;
    logic [4:0]  f5;
    logic        rs2z;
    logic [3:0]  unit;  // fmac fdiv fmv fmis
    ex_ctrl_t    ctrl;
    logic        rm_used;
    logic        dyn;
    logic        no_rs2;
    logic        int_dst;
    logic        int_src;
    logic        fma;
    logic        fp_csr;

    b       = w;
    d       = '0;
    fmt     = b[26:25];
    f3      = b[14:12];
    f5      = b[31:27];
    rs2z    = b[24:20] == 5'd0;
    unit    = 4'b0000;
    ctrl    = EX_NONE;
    rm_used = 1'b0;
    dyn     = 1'b0;
    no_rs2  = 1'b0;
    int_dst = 1'b0;
    int_src = 1'b0;
    fma     = 1'b0;

    // register fields that no form remaps keep their R-view positions
    d.regs.frd  = b[11:7];
    d.regs.frs1 = b[19:15];
    d.regs.frs2 = b[24:20];
    d.regs.frs3 = f5;

    is_ld = b[6:0] == OPC_LOAD_FP;
    is_st = b[6:0] == OPC_STORE_FP;
    case (f3)
        3'b001: {d.ls.lhw, d.ls.shw} = {is_ld, is_st};
        3'b010: {d.ls.lw, d.ls.sw} = {is_ld, is_st};
        3'b011: {d.ls.ld, d.ls.sd} = {is_ld, is_st} & {2{flen == 64}};
        default: ;
    endcase
    dbl = flen == 64 && c_dp_en;
    if (b[1:0] == 2'b00) begin
        d.ls.c_lw = b[15:13] == 3'b011;
        d.ls.c_sw = b[15:13] == 3'b111;
        d.ls.c_ld = b[15:13] == 3'b001 && dbl;
        d.ls.c_sd = b[15:13] == 3'b101 && dbl;
    end else if (b[1:0] == 2'b10) begin
        d.ls.c_lwsp = b[15:13] == 3'b011;
        d.ls.c_swsp = b[15:13] == 3'b111;
        d.ls.c_ldsp = b[15:13] == 3'b001 && dbl;
        d.ls.c_sdsp = b[15:13] == 3'b101 && dbl;
    end
    loads  = d.ls.lhw | d.ls.lw | d.ls.ld | d.ls.c_lw | d.ls.c_ld | d.ls.c_lwsp | d.ls.c_ldsp;
    stores = d.ls.shw | d.ls.sw | d.ls.sd | d.ls.c_sw | d.ls.c_sd | d.ls.c_swsp | d.ls.c_sdsp;
    if (loads | stores) begin
        d.is_fp          = 1'b1;
        d.regs.frs3      = 5'd0;
        d.regs.frd_wen   = loads;
        d.regs.frs2_ren  = stores;
        d.regs.rs1_ren   = 1'b1;
        if (d.ls.c_lw | d.ls.c_ld) begin
            d.regs.frd = {2'b01, b[4:2]};
        end
        if (d.ls.c_lw | d.ls.c_ld | d.ls.c_sw | d.ls.c_sd) begin
            d.regs.frs1 = {2'b01, b[9:7]};
        end
        if (d.ls.c_sw | d.ls.c_sd) begin
            d.regs.frs2 = {2'b01, b[4:2]};
        end
        if (d.ls.c_swsp | d.ls.c_sdsp) begin
            d.regs.frs2 = b[6:2];
        end
    end

    if (fmt == FMT_S || fmt == FMT_H || (fmt == FMT_D && flen == 64)) begin
        case (b[6:0])
            OPC_MADD: begin
                fma  = 1'b1;
                ctrl = EX_FMADD;
            end
            OPC_MSUB: begin
                fma  = 1'b1;
                ctrl = EX_FMSUB;
            end
            OPC_NMSUB: begin
                fma  = 1'b1;
                ctrl = EX_FNMSUB;
            end
            OPC_NMADD: begin
                fma  = 1'b1;
                ctrl = EX_FNMADD;
            end
            OPC_OP_FP: begin
                case (f5)
                    F5_FADD, F5_FSUB, F5_FMUL: begin
                        unit    = 4'b1000;
                        rm_used = 1'b1;
                        ctrl    = (f5 == F5_FADD) ? EX_FADD : (f5 == F5_FSUB) ? EX_FSUB : EX_FMUL;
                    end
                    F5_FDIV: begin
                        unit    = 4'b0100;
                        rm_used = 1'b1;
                        ctrl    = EX_FDIV;
                    end
                    F5_FSQRT: if (rs2z) begin
                        unit    = 4'b0100;
                        rm_used = 1'b1;
                        no_rs2  = 1'b1;
                        ctrl    = EX_FSQRT;
                    end
                    F5_FSGNJ: if (f3 <= 3'd2) begin
                        unit = 4'b0010;
                        ctrl = (f3 == 3'd0) ? EX_FSGNJ : (f3 == 3'd1) ? EX_FSGNJN : EX_FSGNJX;
                    end
                    F5_FMINMAX: if (f3 <= 3'd1) begin
                        unit = 4'b0001;
                        ctrl = (f3 == 3'd0) ? EX_FMIN : EX_FMAX;
                    end
                    F5_FCMP: if (f3 <= 3'd2) begin
                        unit    = 4'b0001;
                        int_dst = 1'b1;
                        ctrl    = (f3 == 3'd0) ? EX_FLE : (f3 == 3'd1) ? EX_FLT : EX_FEQ;
                    end
                    F5_FMVX_CLASS: if (rs2z && f3 <= 3'd1) begin
                        unit    = (f3 == 3'd0) ? 4'b0010 : 4'b0001;
                        int_dst = 1'b1;
                        no_rs2  = 1'b1;
                        ctrl    = (f3 == 3'd0) ? EX_FMVXF : EX_FCLASS;
                    end
                    F5_FMVF: if (rs2z && f3 == 3'd0 && fmt != FMT_D) begin
                        unit    = 4'b0010;
                        int_src = 1'b1;
                        no_rs2  = 1'b1;
                        ctrl    = EX_FMVFX;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end
    if (fma) begin
        unit    = 4'b1000;
        rm_used = 1'b1;
    end

    if (unit != 4'b0000) begin
        d.is_fp = 1'b1;
        {d.ex.fmac, d.ex.fdiv, d.ex.fmv, d.ex.fmis} = unit;
        d.ex.ctrl = ctrl;
        d.ex.sew  = (fmt == FMT_D) ? 3'b100 : (fmt == FMT_S) ? 3'b010 : 3'b001;
        if (rm_used) begin
            dyn     = f3 == RM_DYN;
            d.ex.rm = dyn ? frm : f3;  // static rm passes through untouched
        end
        d.regs.frd_wen  = !int_dst;
        d.regs.rd_wen   = int_dst;
        d.regs.frs1_ren = !int_src;
        d.regs.rs1_ren  = int_src;
        d.regs.frs2_ren = !no_rs2;
        d.regs.frs3_ren = fma;
    end

    fp_csr = csr_acc && (b[31:20] == CSR_FFLAGS || b[31:20] == CSR_FRM || b[31:20] == CSR_FCSR);
    d.trap.off_xcpt = fs == FS_OFF && (d.is_fp || fp_csr);
    d.trap.illegal  = d.trap.off_xcpt
                      || (d.is_fp && (d.ex.rm inside {3'b101, 3'b110} || (dyn && d.ex.rm == 3'b111)));
    return d;
endfunction

`endif

//--- verif/fp_predec_tb.sv
// self-checking testbench for the FP predecoder, random FP words checked against a reference model
module fp_predec_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fp_isa_pkg::*;
    import fp_dec_pkg::*;

    `include "fp_predec_ref.svh"

    localparam int N_ITEMS        = 600;
    localparam int TIMEOUT_CYCLES = 2 * N_ITEMS + 20;
    localparam logic [4:0] F5_LIST [10] = '{F5_FADD, F5_FSUB, F5_FMUL, F5_FDIV, F5_FSQRT,
                                            F5_FSGNJ, F5_FMINMAX, F5_FCMP, F5_FMVX_CLASS, F5_FMVF};

    typedef struct packed {
        logic    valid;
        fp_dec_t dec;
    } exp_item_t;

    logic      clk;
    logic      arst_n;
    logic      instr_valid;
    fp_instr_u instr;
    logic      isa_c_dp_fls_en;
    rm_t       csr_frm;
    fs_e       csr_mstatus_fs;
    logic      instr_csr;
    logic      dec_valid;
    fp_dec_t   dec;

    logic [31:0] lfsr_state;
    exp_item_t   exp_q[$];
    int          cycle_cnt;

    fp_predec #(.FLEN(64)) dut_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .isa_c_dp_fls_en (isa_c_dp_fls_en),
        .csr_frm         (csr_frm),
        .csr_mstatus_fs  (csr_mstatus_fs),
        .instr_csr       (instr_csr),
        .dec_valid       (dec_valid),
        .dec             (dec)
    );

    always #20 clk = ~clk;

    // taps 32 22 2 1, one step per bit handed out
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic report_failure(string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_valid(logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch dec_valid got %h exp %h", got, exp));
        end
    endtask

    task automatic check_ls(fp_ls_t got, fp_ls_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch dec.ls got %h exp %h", got, exp));
        end
    endtask

    task automatic check_regs(fp_regs_t got, fp_regs_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch dec.regs got %h exp %h", got, exp));
        end
    endtask

    task automatic check_ex(fp_ex_t got, fp_ex_t exp, fp_trap_t got_trap, fp_trap_t exp_trap,
                            logic got_fp, logic exp_fp);
        if (got_fp !== exp_fp) begin
            report_failure($sformatf("mismatch dec.is_fp got %h exp %h", got_fp, exp_fp));
        end
        if (got !== exp) begin
            report_failure($sformatf("mismatch dec.ex got %h exp %h", got, exp));
        end
        if (got_trap !== exp_trap) begin
            report_failure($sformatf("mismatch dec.trap got %h exp %h", got_trap, exp_trap));
        end
    endtask

    // one word per call, mostly built from legal templates
    task automatic drive_item();
        logic [31:0] w;
        logic [2:0]  kind;
        int          idx;
        kind      = 3'(take_bits(3));
        w         = take_bits(32);
        instr_csr = 1'b0;
        case (kind)
            3'd0: begin
                w[6:0]   = (take_bits(1) != 0) ? OPC_LOAD_FP : OPC_STORE_FP;
                w[14:12] = {1'b0, 2'(take_bits(2))};
            end
            3'd1: w[0] = 1'b0;  // compressed quadrant 0 or 2
            3'd2: w[6:0] = {3'b100, 2'(take_bits(2)), 2'b11};
            3'd3, 3'd4: begin
                idx       = int'(take_bits(4) % 32'd10);
                w[6:0]    = OPC_OP_FP;
                w[31:27]  = F5_LIST[idx];
                if (take_bits(1) != 0) begin
                    w[24:20] = 5'd0;
                end
                if (take_bits(1) != 0) begin
                    w[14:12] = {1'b0, 2'(take_bits(2))};
                end
            end
            3'd5: w[6:0] = OPC_OP_FP;
            3'd6: begin
                w[31:20]  = {10'd0, 2'(take_bits(2))};
                w[6:0]    = 7'b1110011;
                instr_csr = 1'b1;
            end
            default: ;
        endcase
        instr           = w;
        instr_valid     = take_bits(2) != 0;
        isa_c_dp_fls_en = 1'(take_bits(1));
        csr_frm         = 3'(take_bits(3));
        csr_mstatus_fs  = fs_e'(2'(take_bits(2)));
    endtask

    // outputs at a falling edge belong to the inputs seen one falling edge earlier
    initial begin : compare_proc
        exp_item_t item;
        fp_dec_t   held;
        held = '0;
        exp_q.push_back('0);
        @(posedge arst_n);
        forever begin
            @(negedge clk);
            item = exp_q.pop_front();
            check_valid(dec_valid, item.valid);
            check_ls(dec.ls, item.dec.ls);
            check_regs(dec.regs, item.dec.regs);
            check_ex(dec.ex, item.dec.ex, dec.trap, item.dec.trap, dec.is_fp, item.dec.is_fp);
            if (instr_valid) begin
                held = ref_decode(instr, isa_c_dp_fls_en, csr_frm, csr_mstatus_fs, instr_csr, 64);
            end
            exp_q.push_back({instr_valid, held});
        end
    end

    initial begin : timeout_proc
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt > TIMEOUT_CYCLES) begin
                report_failure($sformatf("timeout, the test did not end within %0d cycles",
                                         TIMEOUT_CYCLES));
            end
        end
    end

    initial begin : stimulus_proc
        clk             = 1'b0;
        arst_n          = 1'b0;
        instr_valid     = 1'b0;
        instr           = '0;
        isa_c_dp_fls_en = 1'b0;
        csr_frm         = '0;
        csr_mstatus_fs  = FS_OFF;
        instr_csr       = 1'b0;
        lfsr_state      = 32'h2742;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (int i = 0; i < N_ITEMS; i++) begin
            @(posedge clk);
            #2;
            drive_item();
        end
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        repeat (3) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- rtl/fp_predec.sv
// FP predecoder top, one registered decoded record per fetched instruction word
module fp_predec #(
    parameter int FLEN = 64
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  fp_isa_pkg::fp_instr_u instr,
    input  logic                  isa_c_dp_fls_en,
    input  fp_isa_pkg::rm_t       csr_frm,
    input  fp_isa_pkg::fs_e       csr_mstatus_fs,
    input  logic                  instr_csr,
    output logic                  dec_valid,
    output fp_dec_pkg::fp_dec_t   dec
);
    import fp_dec_pkg::*;

    fp_ls_t   ls;
    fp_regs_t ls_regs;
    fp_regs_t op_regs;
    fp_ex_t   ex;
    fp_trap_t trap;
    fp_dec_t  dec_d;
    logic     ls_hit;
    logic     op_hit;
    logic     rm_dyn;
    logic     is_fp;

    fp_ls_decode #(.FLEN(FLEN)) ls_dec_i (
        .instr           (instr),
        .isa_c_dp_fls_en (isa_c_dp_fls_en),
        .ls              (ls),
        .ls_regs         (ls_regs),
        .ls_hit          (ls_hit)
    );

    fp_op_decode #(.FLEN(FLEN)) op_dec_i (
        .instr   (instr),
        .csr_frm (csr_frm),
        .op_regs (op_regs),
        .ex      (ex),
        .op_hit  (op_hit),
        .rm_dyn  (rm_dyn)
    );

    assign is_fp = ls_hit | op_hit;

    fp_legal_check legal_i (
        .is_fp          (is_fp),
        .rm             (ex.rm),
        .rm_dyn         (rm_dyn),
        .instr          (instr),
        .instr_csr      (instr_csr),
        .csr_mstatus_fs (csr_mstatus_fs),
        .trap           (trap)
    );

    always_comb begin
        dec_d.is_fp   = is_fp;
        dec_d.ls      = ls;
        dec_d.regs    = ls_hit ? ls_regs : op_regs;
        dec_d.ex      = ex;
        dec_d.ex.fmis = ex.fmis & ~ls_hit;  // loads and stores go to the LSU, not a misc unit
        dec_d.trap    = trap;
    end

    // single pipeline stage, record only advances with a valid word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= instr_valid;
            if (instr_valid) begin
                dec <= dec_d;
            end
        end
    end

endmodule

//--- rtl/fp_legal_check.sv
// exception flags of the FP predecoder from the decoded record and the live CSR state
module fp_legal_check (
    input  logic                  is_fp,
    input  fp_isa_pkg::rm_t       rm,
    input  logic                  rm_dyn,
    input  fp_isa_pkg::fp_instr_u instr,
    input  logic                  instr_csr,
    input  fp_isa_pkg::fs_e       csr_mstatus_fs,
    output fp_dec_pkg::fp_trap_t  trap
);
    import fp_isa_pkg::*;

    logic [11:0] csr_addr;
    logic fp_csr;
    logic fs_off;
    logic rm_bad;

    // CSR address occupies the upper 12 bits of the word
    assign csr_addr = {instr.r.funct5, instr.r.fmt, instr.r.rs2};
    assign fp_csr   = instr_csr && (csr_addr == CSR_FFLAGS || csr_addr == CSR_FRM
                                    || csr_addr == CSR_FCSR);
    assign fs_off   = csr_mstatus_fs == FS_OFF;

    // 111 is only reserved when it came out of frm
    assign rm_bad = rm == 3'b101 || rm == 3'b110 || (rm_dyn && rm == RM_DYN);

    always_comb begin
        trap.off_xcpt = fs_off & (is_fp | fp_csr);
        trap.illegal  = trap.off_xcpt | (is_fp & rm_bad);
    end

endmodule

//--- rtl/fp_op_decode.sv
// FP arithmetic decoder for fused and OP-FP forms, used inside the FP predecoder
module fp_op_decode #(
    parameter int FLEN = 64
) (
    input  fp_isa_pkg::fp_instr_u instr,
    input  fp_isa_pkg::rm_t       csr_frm,
    output fp_dec_pkg::fp_regs_t  op_regs,
    output fp_dec_pkg::fp_ex_t    ex,
    output logic                  op_hit,
    output logic                  rm_dyn
);
    import fp_isa_pkg::*;
    import fp_dec_pkg::*;

    fp_instr_r_t r;
    logic fmt_ok;
    logic is_opfp;
    logic rs2_zero;
    logic f_madd;
    logic f_msub;
    logic f_nmsub;
    logic f_nmadd;
    logic is_fma;
    logic f_add;
    logic f_sub;
    logic f_mul;
    logic f_div;
    logic f_sqrt;
    logic f_sgnj;
    logic f_minmax;
    logic f_cmp;
    logic f_mvx;
    logic f_class;
    logic f_mvf;
    logic uses_rm;
    logic int_rd;

    assign r        = instr.r;
    assign fmt_ok   = r.fmt == FMT_S || r.fmt == FMT_H || (r.fmt == FMT_D && FLEN == 64);
    assign is_opfp  = r.opcode == OPC_OP_FP && fmt_ok;
    assign rs2_zero = r.rs2 == 5'd0;

    assign f_madd   = fmt_ok && r.opcode == OPC_MADD;
    assign f_msub   = fmt_ok && r.opcode == OPC_MSUB;
    assign f_nmsub  = fmt_ok && r.opcode == OPC_NMSUB;
    assign f_nmadd  = fmt_ok && r.opcode == OPC_NMADD;
    assign is_fma   = f_madd | f_msub | f_nmsub | f_nmadd;

    assign f_add    = is_opfp && r.funct5 == F5_FADD;
    assign f_sub    = is_opfp && r.funct5 == F5_FSUB;
    assign f_mul    = is_opfp && r.funct5 == F5_FMUL;
    assign f_div    = is_opfp && r.funct5 == F5_FDIV;
    assign f_sqrt   = is_opfp && r.funct5 == F5_FSQRT && rs2_zero;
    assign f_sgnj   = is_opfp && r.funct5 == F5_FSGNJ && r.funct3 <= 3'd2;
    assign f_minmax = is_opfp && r.funct5 == F5_FMINMAX && r.funct3 <= 3'd1;
    assign f_cmp    = is_opfp && r.funct5 == F5_FCMP && r.funct3 <= 3'd2;
    assign f_mvx    = is_opfp && r.funct5 == F5_FMVX_CLASS && rs2_zero && r.funct3 == 3'd0;
    assign f_class  = is_opfp && r.funct5 == F5_FMVX_CLASS && rs2_zero && r.funct3 == 3'd1;
    // no move into a D register from an integer one
    assign f_mvf    = is_opfp && r.funct5 == F5_FMVF && rs2_zero && r.funct3 == 3'd0
                      && r.fmt != FMT_D;

    assign uses_rm = ex.fmac | ex.fdiv;
    assign rm_dyn  = uses_rm && r.funct3 == RM_DYN;
    assign op_hit  = ex.fmac | ex.fdiv | ex.fmv | ex.fmis;
    assign int_rd  = f_mvx | f_class | f_cmp;

    always_comb begin
        ex.fmac = is_fma | f_add | f_sub | f_mul;
        ex.fdiv = f_div | f_sqrt;
        ex.fmv  = f_sgnj | f_mvx | f_mvf;
        ex.fmis = f_minmax | f_cmp | f_class;
        ex.ctrl = EX_NONE;
        if (f_madd)        ex.ctrl = EX_FMADD;
        else if (f_msub)   ex.ctrl = EX_FMSUB;
        else if (f_nmsub)  ex.ctrl = EX_FNMSUB;
        else if (f_nmadd)  ex.ctrl = EX_FNMADD;
        else if (f_add)    ex.ctrl = EX_FADD;
        else if (f_sub)    ex.ctrl = EX_FSUB;
        else if (f_mul)    ex.ctrl = EX_FMUL;
        else if (f_div)    ex.ctrl = EX_FDIV;
        else if (f_sqrt)   ex.ctrl = EX_FSQRT;
        else if (f_sgnj)   ex.ctrl = (r.funct3 == 3'd0) ? EX_FSGNJ :
                                     (r.funct3 == 3'd1) ? EX_FSGNJN : EX_FSGNJX;
        else if (f_minmax) ex.ctrl = (r.funct3 == 3'd0) ? EX_FMIN : EX_FMAX;
        else if (f_cmp)    ex.ctrl = (r.funct3 == 3'd0) ? EX_FLE :
                                     (r.funct3 == 3'd1) ? EX_FLT : EX_FEQ;
        else if (f_mvx)    ex.ctrl = EX_FMVXF;
        else if (f_class)  ex.ctrl = EX_FCLASS;
        else if (f_mvf)    ex.ctrl = EX_FMVFX;
        ex.sew = op_hit ? {r.fmt == FMT_D, r.fmt == FMT_S, r.fmt == FMT_H} : 3'b000;
        ex.rm  = rm_dyn ? csr_frm : (uses_rm ? r.funct3 : 3'b000);
    end

    always_comb begin
        op_regs.frd      = r.rd;
        op_regs.frs1     = r.rs1;
        op_regs.frs2     = r.rs2;
        op_regs.frs3     = r.funct5;
        op_regs.frd_wen  = op_hit & ~int_rd;
        op_regs.frs1_ren = op_hit & ~f_mvf;
        op_regs.frs2_ren = op_hit & ~(f_sqrt | f_mvx | f_class | f_mvf);  // rs2 is an opcode bit here
        op_regs.frs3_ren = is_fma;
        op_regs.rs1_ren  = f_mvf;
        op_regs.rd_wen   = int_rd;
    end

endmodule

//--- rtl/fp_ls_decode.sv
// FP load/store recognizer for standard and compressed forms, used inside the FP predecoder
module fp_ls_decode #(
    parameter int FLEN = 64
) (
    input  fp_isa_pkg::fp_instr_u instr,
    input  logic                  isa_c_dp_fls_en,
    output fp_dec_pkg::fp_ls_t    ls,
    output fp_dec_pkg::fp_regs_t  ls_regs,
    output logic                  ls_hit
);
    import fp_isa_pkg::*;

    logic is_load;
    logic is_store;
    logic c_q0;
    logic c_q2;
    logic dp_ok;
    logic c_dp_ok;
    logic any_load;
    logic any_store;
    logic [4:0] c_rd_s;
    logic [4:0] c_rs1_s;

    assign is_load  = instr.r.opcode == OPC_LOAD_FP;
    assign is_store = instr.r.opcode == OPC_STORE_FP;
    assign c_q0     = instr.c.op == 2'b00;
    assign c_q2     = instr.c.op == 2'b10;
    assign dp_ok    = FLEN == 64;
    assign c_dp_ok  = dp_ok && isa_c_dp_fls_en;

    // compressed 3-bit fields reach f8..f15
    assign c_rd_s  = {2'b01, instr.c.mid[2:0]};
    assign c_rs1_s = {2'b01, instr.c.mid[7:5]};

    always_comb begin
        ls.lhw    = is_load && instr.r.funct3 == 3'b001;
        ls.lw     = is_load && instr.r.funct3 == 3'b010;
        ls.ld     = is_load && instr.r.funct3 == 3'b011 && dp_ok;
        ls.shw    = is_store && instr.r.funct3 == 3'b001;
        ls.sw     = is_store && instr.r.funct3 == 3'b010;
        ls.sd     = is_store && instr.r.funct3 == 3'b011 && dp_ok;
        ls.c_lw   = c_q0 && instr.c.funct3c == 3'b011;
        ls.c_sw   = c_q0 && instr.c.funct3c == 3'b111;
        ls.c_lwsp = c_q2 && instr.c.funct3c == 3'b011;
        ls.c_swsp = c_q2 && instr.c.funct3c == 3'b111;
        ls.c_ld   = c_q0 && instr.c.funct3c == 3'b001 && c_dp_ok;
        ls.c_sd   = c_q0 && instr.c.funct3c == 3'b101 && c_dp_ok;
        ls.c_ldsp = c_q2 && instr.c.funct3c == 3'b001 && c_dp_ok;
        ls.c_sdsp = c_q2 && instr.c.funct3c == 3'b101 && c_dp_ok;
    end

    assign any_load  = ls.lhw | ls.lw | ls.ld | ls.c_lw | ls.c_ld | ls.c_lwsp | ls.c_ldsp;
    assign any_store = ls.shw | ls.sw | ls.sd | ls.c_sw | ls.c_sd | ls.c_swsp | ls.c_sdsp;
    assign ls_hit    = any_load | any_store;

    always_comb begin
        ls_regs.frd  = (ls.c_lw | ls.c_ld) ? c_rd_s : instr.r.rd;
        ls_regs.frs1 = (ls.c_lw | ls.c_ld | ls.c_sw | ls.c_sd) ? c_rs1_s : instr.r.rs1;
        if (ls.c_swsp | ls.c_sdsp) begin
            ls_regs.frs2 = instr.c.mid[4:0];  // full 5-bit source in SP stores
        end else if (ls.c_sw | ls.c_sd) begin
            ls_regs.frs2 = c_rd_s;
        end else begin
            ls_regs.frs2 = instr.r.rs2;
        end
        ls_regs.frs3     = 5'd0;
        ls_regs.frd_wen  = any_load;
        ls_regs.frs1_ren = 1'b0;
        ls_regs.frs2_ren = any_store;
        ls_regs.frs3_ren = 1'b0;
        ls_regs.rs1_ren  = ls_hit;  // address base is always an integer register
        ls_regs.rd_wen   = 1'b0;
    end

endmodule

//--- rtl/fp_dec_pkg.sv
// decoded FP instruction record and execution control codes, shared by the predecoder and its users
package fp_dec_pkg;

    typedef struct packed {
        logic lhw;
        logic shw;
        logic lw;
        logic sw;
        logic ld;
        logic sd;
        logic c_lw;
        logic c_sw;
        logic c_ld;
        logic c_sd;
        logic c_lwsp;
        logic c_swsp;
        logic c_ldsp;
        logic c_sdsp;
    } fp_ls_t;

    typedef struct packed {
        logic [4:0] frd;
        logic [4:0] frs1;
        logic [4:0] frs2;
        logic [4:0] frs3;
        logic       frd_wen;
        logic       frs1_ren;
        logic       frs2_ren;
        logic       frs3_ren;
        logic       rs1_ren;   // integer source
        logic       rd_wen;    // integer destination
    } fp_regs_t;

    // fdiv and none share a code, the unit class tells them apart
    typedef logic [5:0] ex_ctrl_t;
    localparam ex_ctrl_t EX_FMADD  = 6'b001000;
    localparam ex_ctrl_t EX_FMSUB  = 6'b001001;
    localparam ex_ctrl_t EX_FNMSUB = 6'b001010;
    localparam ex_ctrl_t EX_FNMADD = 6'b001011;
    localparam ex_ctrl_t EX_FADD   = 6'b001100;
    localparam ex_ctrl_t EX_FSUB   = 6'b001101;
    localparam ex_ctrl_t EX_FMUL   = 6'b001110;
    localparam ex_ctrl_t EX_FDIV   = 6'b000000;
    localparam ex_ctrl_t EX_FSQRT  = 6'b000001;
    localparam ex_ctrl_t EX_FSGNJ  = 6'b100000;
    localparam ex_ctrl_t EX_FSGNJN = 6'b100001;
    localparam ex_ctrl_t EX_FSGNJX = 6'b100010;
    localparam ex_ctrl_t EX_FMAX   = 6'b100100;
    localparam ex_ctrl_t EX_FMIN   = 6'b100101;
    localparam ex_ctrl_t EX_FLE    = 6'b101000;
    localparam ex_ctrl_t EX_FLT    = 6'b101001;
    localparam ex_ctrl_t EX_FEQ    = 6'b101010;
    localparam ex_ctrl_t EX_FMVXF  = 6'b101100;
    localparam ex_ctrl_t EX_FCLASS = 6'b101101;
    localparam ex_ctrl_t EX_FMVFX  = 6'b101110;
    localparam ex_ctrl_t EX_NONE   = 6'b000000;

    typedef struct packed {
        logic            fmac;
        logic            fdiv;
        logic            fmv;
        logic            fmis;
        ex_ctrl_t        ctrl;
        logic [2:0]      sew;   // one-hot, D S H from msb down
        fp_isa_pkg::rm_t rm;
    } fp_ex_t;

    typedef struct packed {
        logic illegal;
        logic off_xcpt;
    } fp_trap_t;

    typedef struct packed {
        logic     is_fp;
        fp_ls_t   ls;
        fp_regs_t regs;
        fp_ex_t   ex;
        fp_trap_t trap;
    } fp_dec_t;

endpackage

//--- rtl/fp_isa_pkg.sv
// RISC-V FP instruction encodings and CSR field types, imported by the FP predecoder blocks
package fp_isa_pkg;

    // 32-bit R/R4 view; rs3 of the fused forms sits in funct5
    typedef enum logic [1:0] {
        FMT_S = 2'b00,
        FMT_D = 2'b01,
        FMT_H = 2'b10
    } fmt_e;

    typedef struct packed {
        logic [4:0] funct5;
        fmt_e       fmt;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } fp_instr_r_t;

    typedef struct packed {
        logic [15:0] unused;  // upper half of the fetch word, not part of a compressed form
        logic [2:0]  funct3c;
        logic [10:0] mid;     // bits 12:2 hold the register fields
        logic [1:0]  op;
    } fp_instr_c_t;

    typedef union packed {
        fp_instr_r_t r;
        fp_instr_c_t c;
    } fp_instr_u;

    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
    localparam logic [6:0] OPC_MADD     = 7'b1000011;
    localparam logic [6:0] OPC_MSUB     = 7'b1000111;
    localparam logic [6:0] OPC_NMSUB    = 7'b1001011;
    localparam logic [6:0] OPC_NMADD    = 7'b1001111;
    localparam logic [6:0] OPC_OP_FP    = 7'b1010011;

    localparam logic [4:0] F5_FADD       = 5'b00000;
    localparam logic [4:0] F5_FSUB       = 5'b00001;
    localparam logic [4:0] F5_FMUL       = 5'b00010;
    localparam logic [4:0] F5_FDIV       = 5'b00011;
    localparam logic [4:0] F5_FSQRT      = 5'b01011;
    localparam logic [4:0] F5_FSGNJ      = 5'b00100;
    localparam logic [4:0] F5_FMINMAX    = 5'b00101;
    localparam logic [4:0] F5_FCMP       = 5'b10100;
    localparam logic [4:0] F5_FMVX_CLASS = 5'b11100;
    localparam logic [4:0] F5_FMVF       = 5'b11110;

    typedef logic [2:0] rm_t;
    localparam rm_t RM_DYN = 3'b111;

    typedef enum logic [1:0] {
        FS_OFF   = 2'd0,
        FS_INIT  = 2'd1,
        FS_CLEAN = 2'd2,
        FS_DIRTY = 2'd3
    } fs_e;

    localparam logic [11:0] CSR_FFLAGS = 12'h001;
    localparam logic [11:0] CSR_FRM    = 12'h002;
    localparam logic [11:0] CSR_FCSR   = 12'h003;

endpackage
